/* hdl/board_defines.svh */
// board control core constants
// address map of the main register space, channel count and
// the over-current rule used by the safety checks
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// ------------------------------------------------------------
// address map, reg_addr[15:12] space, [7:4] channel, [3:0] offset
// ------------------------------------------------------------
`define ADDR_MAIN      4'h0     // main register space

// channel 0 offsets
`define OFF_STATUS     4'h0     // board status and amp enables

// channel 1..N offsets
`define OFF_ADC_DATA   4'h0     // current feedback
`define OFF_DAC_CTRL   4'h1     // commanded current

// ------------------------------------------------------------
// channels and real-time block write
// ------------------------------------------------------------
`define NUM_CHANNELS   4
`define RT_CTRL_ADDR   3'd4     // rt quadlet that kicks off the replay

// ------------------------------------------------------------
// safety check
// ------------------------------------------------------------
`define SAFETY_MARGIN  16'h0100 // slack on top of 2x command
`define SAFETY_HOLD    8        // violating cycles before latching
`define MID_SCALE      16'h8000 // zero current, offset binary

`endif

/* hdl/board_pkg.sv */
// board control core types
// write bus shared by the three masters, real-time write port,
// per-channel current vectors and channel masks

`include "board_defines.svh"

package board_pkg;

    // register write bus, driven by fw, eth or the rt block writer
    typedef struct packed {
        logic        wen;          // quadlet write strobe
        logic        blk_wen;      // block write done
        logic        blk_wstart;   // block write starting
        logic [15:0] waddr;        // space, channel, offset
        logic [31:0] wdata;
    } wr_bus_t;

    // real-time quadlet write from the host side
    typedef struct packed {
        logic        wen;
        logic [2:0]  addr;         // 0..3 channel words, 4 = go
        logic [31:0] data;
    } rt_wr_t;

    // one 16-bit code per channel, element 0 is channel 1
    typedef logic [`NUM_CHANNELS-1:0][15:0] cur_vec_t;

    // one bit per channel
    typedef logic [`NUM_CHANNELS-1:0] chan_mask_t;

endpackage

/* hdl/rt_write_arbiter.sv */
// real-time block writer and write bus arbiter
// collects the four rt current words, replays them as a six-cycle block
// write on the go quadlet, otherwise hands the bus to eth or fw

`timescale 1ns/10ps

`include "board_defines.svh"

module rt_write_arbiter (
    input  logic               sysclk,
    input  logic               rst,
    input  board_pkg::rt_wr_t  rt_wr,
    input  board_pkg::wr_bus_t fw_wr,
    input  board_pkg::wr_bus_t eth_wr,
    input  logic               eth_write_en,
    output board_pkg::wr_bus_t wr_bus
);

    localparam logic [2:0] LAST_STEP = 3'(`NUM_CHANNELS + 1);  // blk_wen step

    logic [15:0]        rt_word [`NUM_CHANNELS];  // staged current words
    logic               replay_active;            // rt writer owns the bus
    logic [2:0]         replay_step;
    logic [3:0]         replay_chan;
    logic [3:0]         word_sel;
    board_pkg::wr_bus_t replay_bus;

    // word capture, ignored while replaying
    always_ff @(posedge sysclk) begin
        if (rt_wr.wen && !replay_active && (rt_wr.addr < 3'(`NUM_CHANNELS))) begin
            rt_word[rt_wr.addr[1:0]] <= rt_wr.data[15:0];
        end
    end

    // ------------------------------------------------------------
    // replay sequencer
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            replay_active <= 1'b0;
            replay_step   <= 3'd0;
        end else if (replay_active) begin
            if (replay_step == LAST_STEP) begin
                replay_active <= 1'b0;     // bus back to the hosts
                replay_step   <= 3'd0;
            end else begin
                replay_step <= replay_step + 3'd1;
            end
        end else if (rt_wr.wen && (rt_wr.addr == `RT_CTRL_ADDR)) begin
            replay_active <= 1'b1;         // starts next cycle
            replay_step   <= 3'd0;
        end
    end

    // step 0 start, 1..4 channel writes, 5 block done at last channel
    assign replay_chan = (replay_step == 3'd0)      ? 4'd1 :
                         (replay_step == LAST_STEP) ? 4'(`NUM_CHANNELS) :
                                                      {1'b0, replay_step};
    assign word_sel = replay_chan - 4'd1;

    always_comb begin
        replay_bus            = '0;
        replay_bus.waddr      = {`ADDR_MAIN, 4'd0, replay_chan, `OFF_DAC_CTRL};
        replay_bus.wdata      = {16'd0, rt_word[word_sel[1:0]]};
        replay_bus.blk_wstart = (replay_step == 3'd0);
        replay_bus.wen        = (replay_step != 3'd0) && (replay_step != LAST_STEP);
        replay_bus.blk_wen    = (replay_step == LAST_STEP);
    end

    // priority rt > eth > fw
    assign wr_bus = replay_active ? replay_bus :
                    eth_write_en  ? eth_wr     : fw_wr;

endmodule

/* hdl/cur_cmd_regs.sv */
// commanded-current registers
// one 16-bit command per channel written over the main space,
// block writes raise a DAC update request held until the DAC is free

`timescale 1ns/10ps

`include "board_defines.svh"

module cur_cmd_regs (
    input  logic                sysclk,
    input  logic                rst,
    input  board_pkg::wr_bus_t  wr_bus,
    input  logic                dac_busy,
    output board_pkg::cur_vec_t cur_cmd,
    output logic                dac_update    // one-cycle start to the DAC
);

    logic       dac_addr_hit;   // main space, nonzero chan, DAC offset
    logic [3:0] wr_chan;
    logic [3:0] wr_idx;
    logic       cur_cmd_req;    // pending update, merges repeats

    assign wr_chan = wr_bus.waddr[7:4];
    assign wr_idx  = wr_chan - 4'd1;

    assign dac_addr_hit = (wr_bus.waddr[15:12] == `ADDR_MAIN) &&
                          (wr_chan != 4'd0) &&
                          (wr_bus.waddr[3:0] == `OFF_DAC_CTRL);

    always_ff @(posedge sysclk) begin
        if (rst) begin
            cur_cmd <= {`NUM_CHANNELS{`MID_SCALE}};   // zero current
        end else if (wr_bus.wen && dac_addr_hit && (wr_chan <= 4'(`NUM_CHANNELS))) begin
            cur_cmd[wr_idx[1:0]] <= wr_bus.wdata[15:0];
        end
    end

    // ------------------------------------------------------------
    // update request
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            cur_cmd_req <= 1'b0;
        end else if (wr_bus.blk_wen && dac_addr_hit) begin
            cur_cmd_req <= 1'b1;              // set wins over release
        end else if (dac_update) begin
            cur_cmd_req <= 1'b0;
        end
    end

    assign dac_update = cur_cmd_req & ~dac_busy;

endmodule

/* hdl/dac_serializer.sv */
// quad DAC SPI shifter
// latches all channel commands on an update, sends channel 1 first,
// msb first, one bit per two clocks; data sampled on rising sclk

`timescale 1ns/10ps

`include "board_defines.svh"

module dac_serializer (
    input  logic                sysclk,
    input  logic                rst,
    input  board_pkg::cur_vec_t cur_cmd,
    input  logic                dac_update,
    output logic                dac_busy,
    output logic                dac_sclk,
    output logic                dac_mosi,
    output logic                dac_csel     // active low
);

    localparam int FRAME_BITS = 16 * `NUM_CHANNELS;       // 64
    localparam int CNT_W      = $clog2(2 * FRAME_BITS);   // 128 clocks

    logic [FRAME_BITS-1:0] frame;       // channel 1 in the top word
    logic [FRAME_BITS-1:0] shift_reg;   // payload, no reset
    logic [CNT_W-1:0]      bit_cnt;     // even = sclk low, odd = high

    always_comb begin
        for (int i = 0; i < `NUM_CHANNELS; i++) begin
            frame[FRAME_BITS-1-16*i -: 16] = cur_cmd[i];
        end
    end

    // ------------------------------------------------------------
    // frame sequencer
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            dac_busy <= 1'b0;
            dac_sclk <= 1'b0;
            bit_cnt  <= '0;
        end else if (!dac_busy) begin
            if (dac_update) begin
                dac_busy <= 1'b1;
                bit_cnt  <= '0;
            end
            dac_sclk <= 1'b0;
        end else begin
            bit_cnt  <= bit_cnt + 1'b1;
            dac_sclk <= ~bit_cnt[0];               // low again after last high
            if (bit_cnt == '1) begin
                dac_busy <= 1'b0;                  // 128th clock done
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (!dac_busy && dac_update) begin
            shift_reg <= frame;
        end else if (dac_busy && bit_cnt[0]) begin
            shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b0};  // next bit, sclk falls
        end
    end

    assign dac_mosi = dac_busy & shift_reg[FRAME_BITS-1];
    assign dac_csel = ~dac_busy;

endmodule

/* hdl/safety_check.sv */
// over-current check for one channel
// flags feedback further from zero than twice the command plus a margin,
// latches an amp disable after a run of violating cycles

`timescale 1ns/10ps

`include "board_defines.svh"

module safety_check (
    input  logic        sysclk,
    input  logic        rst,
    input  logic [15:0] cur_in,         // feedback, offset binary
    input  logic [15:0] cmd_in,         // command, offset binary
    input  logic        clear_disable,  // amp enable rewrite
    output logic        amp_disable
);

    localparam int CNT_W = $clog2(`SAFETY_HOLD);

    logic [15:0]      cur_mag;    // |cur - mid|
    logic [15:0]      cmd_mag;    // |cmd - mid|
    logic [17:0]      limit;      // 2*cmd_mag + margin, no overflow
    logic             violation;
    logic [CNT_W-1:0] viol_cnt;   // consecutive violating cycles

    assign cur_mag = (cur_in >= `MID_SCALE) ? (cur_in - `MID_SCALE) : (`MID_SCALE - cur_in);
    assign cmd_mag = (cmd_in >= `MID_SCALE) ? (cmd_in - `MID_SCALE) : (`MID_SCALE - cmd_in);

    assign limit     = {1'b0, cmd_mag, 1'b0} + {2'b00, `SAFETY_MARGIN};
    assign violation = {2'b00, cur_mag} > limit;

    always_ff @(posedge sysclk) begin
        if (rst || clear_disable) begin
            viol_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (violation) begin
            if (viol_cnt == CNT_W'(`SAFETY_HOLD - 1)) begin
                amp_disable <= 1'b1;             // sticky until cleared
            end else begin
                viol_cnt <= viol_cnt + 1'b1;
            end
        end else begin
            viol_cnt <= '0;                      // run broken
        end
    end

endmodule

/* hdl/board_regs.sv */
// board status register, channel 0
// holds the amp enables, pulses the enable commands that clear the
// safety disables, and builds the status word with the board id

`timescale 1ns/10ps

`include "board_defines.svh"

module board_regs (
    input  logic                  sysclk,
    input  logic                  rst,
    input  board_pkg::wr_bus_t    wr_bus,
    input  board_pkg::chan_mask_t safety_disable,
    input  logic [3:0]            board_id,
    output board_pkg::chan_mask_t amp_enable,
    output board_pkg::chan_mask_t amp_enable_cmd,  // one-cycle per channel
    output logic [31:0]           status_word
);

    logic                  status_wr;
    board_pkg::chan_mask_t amp_en_q;     // stored enables
    board_pkg::chan_mask_t wr_bits;

    assign status_wr = wr_bus.wen &&
                       (wr_bus.waddr[15:12] == `ADDR_MAIN) &&
                       (wr_bus.waddr[7:4] == 4'd0) &&
                       (wr_bus.waddr[3:0] == `OFF_STATUS);
    assign wr_bits   = wr_bus.wdata[`NUM_CHANNELS-1:0];

    // ------------------------------------------------------------
    // enables and command pulses
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            amp_en_q       <= '0;
            amp_enable_cmd <= '0;
        end else begin
            amp_enable_cmd <= status_wr ? wr_bits : '0;
            if (status_wr) begin
                amp_en_q <= wr_bits;
            end else begin
                // disable still set while its clear pulse is out
                amp_en_q <= amp_en_q & ~(safety_disable & ~amp_enable_cmd);
            end
        end
    end

    assign amp_enable = amp_en_q & ~safety_disable;

    // id 27:24, disables 11:8, enables 3:0
    assign status_word = {4'd0, board_id, 12'd0, safety_disable, 4'd0, amp_en_q};

endmodule

/* hdl/reg_read_mux.sv */
// register read mux
// one-cycle registered read of status, commanded and feedback currents

`timescale 1ns/10ps

`include "board_defines.svh"

module reg_read_mux (
    input  logic                sysclk,
    input  logic                rst,
    input  logic [15:0]         reg_raddr,
    input  logic [31:0]         status_word,
    input  board_pkg::cur_vec_t cur_cmd,
    input  board_pkg::cur_vec_t cur_fb,
    output logic [31:0]         reg_rdata
);

    logic [3:0] rd_chan;
    logic [3:0] rd_idx;       // channel 1..N to vector index
    logic       rd_main;
    logic       chan_ok;

    assign rd_main = (reg_raddr[15:12] == `ADDR_MAIN);
    assign rd_chan = reg_raddr[7:4];
    assign rd_idx  = rd_chan - 4'd1;
    assign chan_ok = (rd_chan <= 4'(`NUM_CHANNELS));

    always_ff @(posedge sysclk) begin
        if (rst) begin
            reg_rdata <= 32'd0;
        end else if (!rd_main || !chan_ok) begin
            reg_rdata <= 32'd0;                            // other spaces unmapped
        end else if (rd_chan == 4'd0) begin
            reg_rdata <= status_word;
        end else if (reg_raddr[3:0] == `OFF_DAC_CTRL) begin
            reg_rdata <= {16'd0, cur_cmd[rd_idx[1:0]]};
        end else if (reg_raddr[3:0] == `OFF_ADC_DATA) begin
            reg_rdata <= {16'd0, cur_fb[rd_idx[1:0]]};
        end else begin
            reg_rdata <= 32'd0;
        end
    end

endmodule

/* hdl/motor_ctrl_top.sv */
// motor controller control core
// write bus arbitration, commanded-current registers with DAC SPI output,
// per-channel over-current safety and the board status register

`timescale 1ns/10ps

`include "board_defines.svh"

module motor_ctrl_top (
    input  logic                   sysclk,
    input  logic                   rst,
    input  board_pkg::wr_bus_t     fw_wr,         // FireWire host writes
    input  board_pkg::wr_bus_t     eth_wr,        // Ethernet host writes
    input  logic                   eth_write_en,  // eth owns the bus
    input  board_pkg::rt_wr_t      rt_wr,
    input  logic [15:0]            reg_raddr,
    input  board_pkg::cur_vec_t    cur_fb,        // current feedback
    input  logic [3:0]             board_id,
    output logic [31:0]            reg_rdata,
    output logic                   dac_sclk,
    output logic                   dac_mosi,
    output logic                   dac_csel,
    output board_pkg::chan_mask_t  amp_enable
);

    board_pkg::wr_bus_t    wr_bus;          // arbitrated write bus
    board_pkg::cur_vec_t   cur_cmd;
    logic                  dac_update;
    logic                  dac_busy;
    board_pkg::chan_mask_t safety_disable;
    board_pkg::chan_mask_t amp_enable_cmd;  // enable pulses, clear disables
    logic [31:0]           status_word;

    // ------------------------------------------------------------
    // write path
    // ------------------------------------------------------------
    rt_write_arbiter u_arb (
        .sysclk(sysclk), .rst(rst), .rt_wr(rt_wr), .fw_wr(fw_wr),
        .eth_wr(eth_wr), .eth_write_en(eth_write_en), .wr_bus(wr_bus)
    );

    cur_cmd_regs u_cmd (
        .sysclk(sysclk), .rst(rst), .wr_bus(wr_bus), .dac_busy(dac_busy),
        .cur_cmd(cur_cmd), .dac_update(dac_update)
    );

    dac_serializer u_dac (
        .sysclk(sysclk), .rst(rst), .cur_cmd(cur_cmd), .dac_update(dac_update),
        .dac_busy(dac_busy), .dac_sclk(dac_sclk), .dac_mosi(dac_mosi),
        .dac_csel(dac_csel)
    );

    // ------------------------------------------------------------
    // safety, one checker per channel
    // ------------------------------------------------------------
    for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : g_safe
        safety_check u_safe (
            .sysclk(sysclk), .rst(rst), .cur_in(cur_fb[i]), .cmd_in(cur_cmd[i]),
            .clear_disable(amp_enable_cmd[i]), .amp_disable(safety_disable[i])
        );
    end

    board_regs u_chan0 (
        .sysclk(sysclk), .rst(rst), .wr_bus(wr_bus), .safety_disable(safety_disable),
        .board_id(board_id), .amp_enable(amp_enable), .amp_enable_cmd(amp_enable_cmd),
        .status_word(status_word)
    );

    // read side
    reg_read_mux u_rd (
        .sysclk(sysclk), .rst(rst), .reg_raddr(reg_raddr), .status_word(status_word),
        .cur_cmd(cur_cmd), .cur_fb(cur_fb), .reg_rdata(reg_rdata)
    );

endmodule

/* bench/motor_ctrl_assert.sv */
// motor controller core assertions
// DAC chip select window, amp enables coming back only through a status
// write, and the six-cycle real-time block write on the shared bus

`timescale 1ns/10ps

module motor_ctrl_assert (
    input logic                  sysclk,
    input logic                  rst,
    input logic                  dac_update,
    input logic                  dac_csel,
    input board_pkg::chan_mask_t amp_enable,
    input board_pkg::chan_mask_t amp_enable_cmd,
    input board_pkg::wr_bus_t    wr_bus
);

    // chip select drops only after an update pulse
    csel_start: assert property (@(posedge sysclk) disable iff (rst)
        $fell(dac_csel) |-> $past(dac_update))
        else $error("dac_csel went low without a DAC update");

    // low for exactly the 128-clock frame
    csel_frame: assert property (@(posedge sysclk) disable iff (rst)
        $rose(dac_csel) |-> !$past(dac_csel, 128) && $past(dac_csel, 129))
        else $error("dac_csel low window is not 128 cycles");

    // a latched disable keeps its channel off until an enable write
    enable_only_by_write: assert property (@(posedge sysclk) disable iff (rst)
        (amp_enable & ~$past(amp_enable) & ~amp_enable_cmd & ~$past(amp_enable_cmd)) == '0)
        else $error("amp enable came back without an enable write");

    // ------------------------------------------------------------
    // replay: start, four quadlets, block done
    // ------------------------------------------------------------
    replay_end: assert property (@(posedge sysclk) disable iff (rst)
        wr_bus.blk_wen |-> $past(wr_bus.blk_wstart, 5) && $past(wr_bus.wen, 4) &&
                           $past(wr_bus.wen, 3) && $past(wr_bus.wen, 2) &&
                           $past(wr_bus.wen, 1))
        else $error("block write done without a six-cycle replay before it");

    replay_done: assert property (@(posedge sysclk) disable iff (rst)
        $past(wr_bus.blk_wstart, 5) |-> wr_bus.blk_wen)
        else $error("replay started but no block done five cycles later");

endmodule

bind motor_ctrl_top motor_ctrl_assert u_assert (
    .sysclk(sysclk), .rst(rst), .dac_update(dac_update), .dac_csel(dac_csel),
    .amp_enable(amp_enable), .amp_enable_cmd(amp_enable_cmd), .wr_bus(wr_bus)
);

/* bench/tb_motor_ctrl.sv */
// motor controller core testbench
// host and real-time writes, register readback, DAC SPI frame decode
// and the over-current disable with its clear through the status register

`timescale 1ns/10ps

`include "board_defines.svh"

module tb_motor_ctrl;

    localparam int MAX_CYCLES = 4000;   // tests run ~400 cycles, 10x margin

    logic                  sysclk = 1'b0;
    logic                  rst;
    board_pkg::wr_bus_t    fw_wr;
    board_pkg::wr_bus_t    eth_wr;
    logic                  eth_write_en;
    board_pkg::rt_wr_t     rt_wr;
    logic [15:0]           reg_raddr;
    board_pkg::cur_vec_t   cur_fb;
    logic [3:0]            board_id;
    logic [31:0]           reg_rdata;
    logic                  dac_sclk;
    logic                  dac_mosi;
    logic                  dac_csel;
    board_pkg::chan_mask_t amp_enable;

    logic [15:0]           model_cmd [`NUM_CHANNELS];  // expected commands
    board_pkg::chan_mask_t model_en;                   // stored enables
    board_pkg::chan_mask_t model_dis;                  // latched disables
    logic                  rd_pending = 1'b0;          // read issued this cycle
    logic [31:0]           rd_expect;
    logic                  chk_valid = 1'b0;           // data due on reg_rdata
    logic [31:0]           chk_exp;
    logic [15:0]           chk_addr;
    logic [63:0]           spi_bits = '0;              // last 64 bits off mosi
    int                    spi_cnt = 0;
    int                    err_cnt = 0;
    int                    check_cnt = 0;
    int                    cycle_cnt = 0;

    motor_ctrl_top DUT (
        .sysclk(sysclk), .rst(rst), .fw_wr(fw_wr), .eth_wr(eth_wr),
        .eth_write_en(eth_write_en), .rt_wr(rt_wr), .reg_raddr(reg_raddr),
        .cur_fb(cur_fb), .board_id(board_id), .reg_rdata(reg_rdata),
        .dac_sclk(dac_sclk), .dac_mosi(dac_mosi), .dac_csel(dac_csel),
        .amp_enable(amp_enable)
    );

    always #2 sysclk = ~sysclk;   // 4 ns

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic logic [15:0] chan_addr(input logic [3:0] ch, input logic [3:0] off);
        return {`ADDR_MAIN, 4'd0, ch, off};
    endfunction

    function automatic board_pkg::wr_bus_t quadlet(input logic [15:0] a, input logic [31:0] d);
        board_pkg::wr_bus_t b;
        b       = '0;
        b.wen   = 1'b1;
        b.waddr = a;
        b.wdata = d;
        return b;
    endfunction

    function automatic logic [31:0] ref_read(input logic [15:0] addr);
        logic [3:0] ch;
        ch = addr[7:4];
        if (addr[15:12] != `ADDR_MAIN || ch > `NUM_CHANNELS) return 32'd0;
        if (ch == 4'd0) return {4'd0, board_id, 12'd0, model_dis, 4'd0, model_en};
        if (addr[3:0] == `OFF_DAC_CTRL) return {16'd0, model_cmd[ch - 4'd1]};
        if (addr[3:0] == `OFF_ADC_DATA) return {16'd0, cur_fb[ch - 4'd1]};
        return 32'd0;
    endfunction

    // channel 1 leaves first, msb first
    function automatic logic [63:0] ref_frame();
        logic [63:0] f;
        f = '0;
        for (int i = 0; i < `NUM_CHANNELS; i++) f = {f[47:0], model_cmd[i]};
        return f;
    endfunction

    function automatic logic ref_violation(input logic [15:0] cur, input logic [15:0] cmd);
        int cur_dist;
        int cmd_dist;
        cur_dist = int'(cur) - int'(`MID_SCALE);
        cmd_dist = int'(cmd) - int'(`MID_SCALE);
        if (cur_dist < 0) cur_dist = -cur_dist;
        if (cmd_dist < 0) cmd_dist = -cmd_dist;
        return cur_dist > 2 * cmd_dist + int'(`SAFETY_MARGIN);
    endfunction

    function automatic board_pkg::chan_mask_t ref_amp();
        return model_en & ~model_dis;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // drivers, all called on a falling edge
    // ------------------------------------------------------------
    task automatic host_write(input logic use_eth, input logic [15:0] a, input logic [31:0] d);
        if (use_eth) eth_wr = quadlet(a, d);
        else fw_wr = quadlet(a, d);
        @(negedge sysclk);
        fw_wr  = '0;
        eth_wr = '0;
    endtask

    task automatic rt_write(input logic [2:0] a, input logic [31:0] d);
        rt_wr = {1'b1, a, d};
        @(negedge sysclk);
        rt_wr = '0;
    endtask

    task automatic read_check(input logic [15:0] a);
        reg_raddr  = a;
        rd_expect  = ref_read(a);
        rd_pending = 1'b1;
        @(negedge sysclk);
        rd_pending = 1'b0;
    endtask

    // read compare, one cycle latency
    always @(posedge sysclk) begin
        chk_valid <= rd_pending;
        chk_exp   <= rd_expect;
        chk_addr  <= reg_raddr;
    end

    always @(negedge sysclk) begin
        if (chk_valid) check_value($sformatf("read at %h", chk_addr), 64'(reg_rdata),
                                   64'(chk_exp));
    end

    // receiver samples mosi on rising sclk
    always @(posedge dac_sclk) begin
        if (!dac_csel) begin
            spi_bits = {spi_bits[62:0], dac_mosi};
            spi_cnt  = spi_cnt + 1;
        end
    end

    always @(posedge sysclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        logic [3:0]  ch;
        logic [31:0] data;
        logic [31:0] data2;
        logic [31:0] rt_words [`NUM_CHANNELS];
        logic [15:0] fb;
        int          c;
        int          spi_start;
        data = $urandom(32'he76e);     // seed
        rst = 1'b1;
        fw_wr = '0;
        eth_wr = '0;
        eth_write_en = 1'b0;
        rt_wr = '0;
        reg_raddr = '0;
        board_id = 4'($urandom);
        model_en = '0;
        model_dis = '0;
        for (int i = 0; i < `NUM_CHANNELS; i++) begin
            cur_fb[i]    = `MID_SCALE;
            model_cmd[i] = `MID_SCALE;
        end
        repeat (2) @(negedge sysclk);
        rst = 1'b0;
        check_value("dac_csel after reset", 64'(dac_csel), 64'd1);
        check_value("dac_sclk after reset", 64'(dac_sclk), 64'd0);
        check_value("amp_enable after reset", 64'(amp_enable), 64'd0);

        // fw quadlet writes, each read back
        for (int n = 0; n < 8; n++) begin
            ch   = 4'd1 + 4'($urandom % `NUM_CHANNELS);
            data = $urandom;
            host_write(1'b0, chan_addr(ch, `OFF_DAC_CTRL), data);
            model_cmd[ch - 4'd1] = data[15:0];
            read_check(chan_addr(ch, `OFF_DAC_CTRL));
        end
        read_check(chan_addr(4'd0, `OFF_STATUS));   // board id in 27:24
        read_check(chan_addr(4'd2, `OFF_ADC_DATA));
        read_check(16'h1011);                        // not main space

        // eth owns the bus, fw write in the same cycle is dropped
        eth_write_en = 1'b1;
        data  = $urandom;
        data2 = $urandom;
        fw_wr  = quadlet(chan_addr(4'd1, `OFF_DAC_CTRL), data);
        eth_wr = quadlet(chan_addr(4'd2, `OFF_DAC_CTRL), data2);
        @(negedge sysclk);
        fw_wr  = '0;
        eth_wr = '0;
        eth_write_en = 1'b0;
        model_cmd[1] = data2[15:0];
        read_check(chan_addr(4'd1, `OFF_DAC_CTRL));
        read_check(chan_addr(4'd2, `OFF_DAC_CTRL));

        // ------------------------------------------------------------
        // rt block write and DAC frame
        // ------------------------------------------------------------
        spi_start = spi_cnt;
        for (int i = 0; i < `NUM_CHANNELS; i++) begin
            rt_words[i] = $urandom;
            rt_write(3'(i), rt_words[i]);
            model_cmd[i] = rt_words[i][15:0];
        end
        rt_write(`RT_CTRL_ADDR, 32'd0);
        host_write(1'b0, chan_addr(4'd0, `OFF_STATUS), 32'hF);   // hits replay step 0
        while (dac_csel) @(negedge sysclk);
        while (!dac_csel) @(negedge sysclk);
        check_value("dac frame bit count", 64'(spi_cnt - spi_start), 64'd64);
        check_value("dac frame", spi_bits, ref_frame());
        check_value("amp_enable after write during replay", 64'(amp_enable), 64'(ref_amp()));
        for (int i = 1; i <= `NUM_CHANNELS; i++) read_check(chan_addr(4'(i), `OFF_DAC_CTRL));
        read_check(chan_addr(4'd0, `OFF_STATUS));

        // amp enables through the status register
        data = $urandom;
        host_write(1'b0, chan_addr(4'd0, `OFF_STATUS), {28'd0, data[3:0]});
        model_en = data[3:0];
        check_value("amp_enable after enable write", 64'(amp_enable), 64'(ref_amp()));
        host_write(1'b0, chan_addr(4'd0, `OFF_STATUS), 32'hF);
        model_en = 4'hF;
        check_value("amp_enable all on", 64'(amp_enable), 64'(ref_amp()));

        // ------------------------------------------------------------
        // over-current on one channel, then recovery
        // ------------------------------------------------------------
        c = $urandom % `NUM_CHANNELS;
        host_write(1'b0, chan_addr(4'(c + 1), `OFF_DAC_CTRL), {16'd0, `MID_SCALE});
        model_cmd[c] = `MID_SCALE;
        fb = 16'h9000 + 16'($urandom % 32'h6000);   // far above the margin
        cur_fb[c] = fb;
        repeat (20) @(negedge sysclk);
        if (ref_violation(fb, model_cmd[c])) begin
            model_dis[c] = 1'b1;
            model_en[c]  = 1'b0;
        end
        check_value("amp_enable with over-current", 64'(amp_enable), 64'(ref_amp()));
        check_value("tripped channel enable", 64'(amp_enable[c]), 64'd0);
        read_check(chan_addr(4'd0, `OFF_STATUS));
        cur_fb[c] = `MID_SCALE;
        @(negedge sysclk);
        host_write(1'b0, chan_addr(4'd0, `OFF_STATUS), 32'hF);
        model_en  = 4'hF;
        model_dis = '0;
        @(negedge sysclk);   // clear pulse reaches the checker
        check_value("amp_enable after re-enable", 64'(amp_enable), 64'(ref_amp()));
        read_check(chan_addr(4'd0, `OFF_STATUS));

        repeat (2) @(negedge sysclk);   // last read compare
        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+hdl
hdl/board_pkg.sv
hdl/rt_write_arbiter.sv
hdl/cur_cmd_regs.sv
hdl/dac_serializer.sv
hdl/safety_check.sv
hdl/board_regs.sv
hdl/reg_read_mux.sv
hdl/motor_ctrl_top.sv
bench/motor_ctrl_assert.sv
bench/tb_motor_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build the motor controller testbench with Verilator, run it, scan the log
LOG=sim.log
rm -f "$LOG" build.log
verilator --binary --assert -Wno-fatal --top-module tb_motor_ctrl \
    -f flist.f -o Vtb_motor_ctrl > build.log 2>&1 \
    && ./obj_dir/Vtb_motor_ctrl > "$LOG" 2>&1 \
    || { cat build.log >> "$LOG"; echo "TEST FAIL" >> "$LOG"; }
cat "$LOG"
grep -q "TEST FAIL" "$LOG" && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
